// File: src/cache_cfg_pkg.sv
package cache_cfg_pkg;

        ////////////////////////////////////////
        // cache geometry
        ////////////////////////////////////////

        localparam int word_bits = 32;
        localparam int line_words = 4;
        localparam int offset_bits = 4;          // byte offset within a line
        localparam int default_num_sets = 2;

        typedef logic [word_bits-1:0] word_t;
        typedef logic [31:0] addr_t;             // byte address
        typedef logic [line_words*word_bits-1:0] line_t;

endpackage

// File: src/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

        // cpu side controller states
        typedef enum logic [1:0] {
                idle,
                lookup,
                refill,
                merge
        } ctrl_state_e;

        // work handed to the memory port on a miss
        typedef enum logic [1:0] {
                none,
                fill,
                evict_fill              // dirty victim goes out before the fill
        } mem_op_e;

endpackage

// File: src/cache_ifs.sv
`timescale 1ns/100ps

////////////////////////////////////////
// lookup path between controller and stores
////////////////////////////////////////

interface lookup_if #(
        parameter int num_sets = cache_cfg_pkg::default_num_sets
);
        localparam int index_bits = $clog2(num_sets);

        cache_cfg_pkg::addr_t addr;
        logic [index_bits-1:0] index;           // set select, taken from addr
        logic fill_en;
        logic write_en;
        cache_cfg_pkg::word_t wdata;
        logic byte_sel;
        logic touch;

        logic hit;
        logic hit_way;
        logic victim_way;
        logic victim_dirty;
        cache_cfg_pkg::addr_t victim_addr;       // line address of the victim
        cache_cfg_pkg::word_t rdata;

        assign index = addr[cache_cfg_pkg::offset_bits +: index_bits];

        modport ctrl (output addr, fill_en, write_en, wdata, byte_sel, touch,
                      input hit, hit_way, victim_dirty, victim_addr, rdata);
        modport tags (input addr, index, fill_en, write_en, touch,
                      output hit, hit_way, victim_way, victim_dirty, victim_addr);
        modport data (input addr, index, fill_en, write_en, wdata, byte_sel, hit_way,
                      victim_way, output rdata);
endinterface

////////////////////////////////////////
// miss handoff to the memory port
////////////////////////////////////////

interface refill_if;
        logic start;                            // one cycle
        cache_ctrl_pkg::mem_op_e op;
        cache_cfg_pkg::addr_t miss_addr;
        cache_cfg_pkg::addr_t victim_addr;
        logic done;                             // one cycle, with the fill's ready_mem
        cache_cfg_pkg::line_t fill_line;

        modport ctrl (output start, op, miss_addr, victim_addr, input done, fill_line);
        modport port (input start, op, miss_addr, victim_addr, output done, fill_line);
endinterface

// File: src/tag_store.sv
`timescale 1ns/100ps

module tag_store #(
        parameter int num_sets = cache_cfg_pkg::default_num_sets
) (
        input logic clk,
        input logic reset,
        lookup_if.tags lk
);
        localparam int index_bits = $clog2(num_sets);
        localparam int tag_bits = 32 - index_bits - cache_cfg_pkg::offset_bits;

        logic [tag_bits-1:0] tag_mem [num_sets][2];
        logic [num_sets-1:0][1:0] valid;
        logic [num_sets-1:0][1:0] dirty;
        logic [num_sets-1:0] lru;               // least recently used way of each set
        logic [tag_bits-1:0] tag;
        logic [1:0] hit_vec;
        logic victim;

        assign tag = lk.addr[31 -: tag_bits];

        ////////////////////////////////////////
        // compare and victim choice
        ////////////////////////////////////////

        assign hit_vec[0] = valid[lk.index][0] && (tag_mem[lk.index][0] == tag);
        assign hit_vec[1] = valid[lk.index][1] && (tag_mem[lk.index][1] == tag);
        assign lk.hit = |hit_vec;
        assign lk.hit_way = hit_vec[1];

        // an empty way wins over the lru way
        assign victim = !valid[lk.index][0] ? 1'b0 :
                        !valid[lk.index][1] ? 1'b1 : lru[lk.index];
        assign lk.victim_way = victim;
        assign lk.victim_dirty = dirty[lk.index][victim];
        assign lk.victim_addr = {tag_mem[lk.index][victim], lk.index,
                                 {cache_cfg_pkg::offset_bits{1'b0}}};

        ////////////////////////////////////////
        // updates
        ////////////////////////////////////////

        always_ff @(posedge clk)
        begin
                if (lk.fill_en)
                begin
                        tag_mem[lk.index][victim] <= tag;
                end
        end

        always_ff @(posedge clk or posedge reset)
        begin
                if (reset)
                begin
                        valid <= '0;
                        dirty <= '0;
                        lru <= '0;
                end
                else if (lk.fill_en)
                begin
                        valid[lk.index][victim] <= 1'b1;
                        dirty[lk.index][victim] <= lk.write_en;   // write miss lands dirty
                        lru[lk.index] <= ~victim;
                end
                else
                begin
                        if (lk.write_en)
                        begin
                                dirty[lk.index][lk.hit_way] <= 1'b1;
                        end
                        if (lk.touch)
                        begin
                                lru[lk.index] <= ~lk.hit_way;
                        end
                end
        end

        // a line is only installed on a miss, so one tag never sits in both ways
        a_one_way_hits: assert property (@(posedge clk) disable iff (reset)
                hit_vec != 2'b11);

endmodule

// File: src/data_store.sv
`timescale 1ns/100ps

module data_store #(
        parameter int num_sets = cache_cfg_pkg::default_num_sets
) (
        input logic clk,
        input logic reset,
        lookup_if.data lk,
        refill_if.ctrl rf,
        output cache_cfg_pkg::line_t victim_line
);
        cache_cfg_pkg::line_t lines [num_sets][2];
        cache_cfg_pkg::line_t src_line;
        cache_cfg_pkg::line_t new_line;
        cache_cfg_pkg::word_t word;
        logic way;
        logic [1:0] word_idx;

        assign way = lk.fill_en ? lk.victim_way : lk.hit_way;
        assign word_idx = lk.addr[3:2];

        // during a fill the incoming line is read through
        assign src_line = lk.fill_en ? rf.fill_line : lines[lk.index][way];
        assign word = src_line[word_idx*cache_cfg_pkg::word_bits +: cache_cfg_pkg::word_bits];
        assign lk.rdata = lk.byte_sel ? cache_cfg_pkg::word_t'(word[lk.addr[1:0]*8 +: 8]) :
                                        word;

        assign victim_line = lines[lk.index][lk.victim_way];   // writeback source

        always_comb
        begin
                new_line = src_line;
                if (lk.write_en)
                begin
                        new_line[word_idx*cache_cfg_pkg::word_bits +: cache_cfg_pkg::word_bits] =
                                lk.wdata;
                end
        end

        always_ff @(posedge clk)
        begin
                if (lk.fill_en || lk.write_en)
                begin
                        lines[lk.index][way] <= new_line;
                end
        end

        // the memory port hands over the line the cycle before it is installed
        a_fill_after_done: assert property (@(posedge clk) disable iff (reset)
                lk.fill_en |-> $past(rf.done));

endmodule

// File: src/mem_port.sv
`timescale 1ns/100ps

module mem_port (
        input logic clk,
        input logic reset,
        refill_if.port rf,
        input cache_cfg_pkg::line_t victim_line,
        input logic ready_mem,
        input logic mem_busy,
        input cache_cfg_pkg::line_t data_mem_read,
        output cache_cfg_pkg::line_t data_mem_write,
        output cache_cfg_pkg::addr_t addr_mem,
        output logic read_mem,
        output logic write_mem
);
        typedef enum logic [2:0] {
                port_idle,
                wb_issue,
                wb_wait,
                rd_issue,
                rd_wait
        } port_state_e;

        port_state_e state;
        cache_cfg_pkg::addr_t miss_q;           // line aligned miss address
        cache_cfg_pkg::line_t line_q;
        logic fill_done;

        assign fill_done = (state == rd_wait) && ready_mem;
        assign rf.done = fill_done;
        assign rf.fill_line = fill_done ? data_mem_read : line_q;  // held until next fill

        always_ff @(posedge clk or posedge reset)
        begin
                if (reset)
                begin
                        state <= port_idle;
                        read_mem <= 1'b0;
                        write_mem <= 1'b0;
                        addr_mem <= '0;
                        miss_q <= '0;
                end
                else
                begin
                        read_mem <= 1'b0;       // request pulses last one cycle
                        write_mem <= 1'b0;
                        case (state)
                        port_idle:
                                if (rf.start)
                                begin
                                        miss_q <= {rf.miss_addr[31:cache_cfg_pkg::offset_bits],
                                                   {cache_cfg_pkg::offset_bits{1'b0}}};
                                        addr_mem <= rf.victim_addr;
                                        if (rf.op == cache_ctrl_pkg::evict_fill)
                                                state <= wb_issue;
                                        else if (rf.op == cache_ctrl_pkg::fill)
                                                state <= rd_issue;
                                end
                        wb_issue:
                                if (!mem_busy)
                                begin
                                        write_mem <= 1'b1;
                                        state <= wb_wait;
                                end
                        wb_wait:
                                if (ready_mem)
                                        state <= rd_issue;
                        rd_issue:
                                if (!mem_busy)
                                begin
                                        read_mem <= 1'b1;
                                        addr_mem <= miss_q;
                                        state <= rd_wait;
                                end
                        default:
                                if (ready_mem)
                                        state <= port_idle;
                        endcase
                end
        end

        always_ff @(posedge clk)
        begin
                if (state == port_idle && rf.start)
                        data_mem_write <= victim_line;
                if (fill_done)
                        line_q <= data_mem_read;
        end

        a_one_request: assert property (@(posedge clk) disable iff (reset)
                !(read_mem && write_mem));

endmodule

// File: src/cache_control.sv
`timescale 1ns/100ps

module cache_control (
        input logic clk,
        input logic reset,
        input logic read_cpu,
        input logic write_cpu,
        input logic byte_sel,
        input cache_cfg_pkg::word_t data_cpu_write,
        input cache_cfg_pkg::addr_t addr_cpu,
        output cache_cfg_pkg::word_t data_cpu_read,
        output logic stall,
        lookup_if.ctrl lk,
        refill_if.ctrl rf
);
        cache_ctrl_pkg::ctrl_state_e state;
        cache_cfg_pkg::addr_t addr_q;
        cache_cfg_pkg::word_t wdata_q;
        logic byte_q;
        logic write_q;                          // latched request is a write
        logic accept;
        logic hit_now;

        assign accept = (state == cache_ctrl_pkg::idle) && (read_cpu || write_cpu);
        assign hit_now = (state == cache_ctrl_pkg::lookup) && lk.hit;

        ////////////////////////////////////////
        // store side controls
        ////////////////////////////////////////

        assign lk.addr = addr_q;
        assign lk.wdata = wdata_q;
        assign lk.byte_sel = byte_q;
        assign lk.touch = hit_now;
        assign lk.fill_en = (state == cache_ctrl_pkg::merge);
        assign lk.write_en = write_q && (hit_now || state == cache_ctrl_pkg::merge);

        assign rf.start = (state == cache_ctrl_pkg::lookup) && !lk.hit;
        assign rf.miss_addr = addr_q;
        assign rf.victim_addr = lk.victim_addr;

        always_comb
        begin
                if (!rf.start)
                        rf.op = cache_ctrl_pkg::none;
                else if (lk.victim_dirty)
                        rf.op = cache_ctrl_pkg::evict_fill;
                else
                        rf.op = cache_ctrl_pkg::fill;
        end

        ////////////////////////////////////////
        // fsm
        ////////////////////////////////////////

        always_ff @(posedge clk or posedge reset)
        begin
                if (reset)
                begin
                        state <= cache_ctrl_pkg::idle;
                        stall <= 1'b0;
                        write_q <= 1'b0;
                end
                else
                begin
                        case (state)
                        cache_ctrl_pkg::idle:
                                if (accept)
                                begin
                                        state <= cache_ctrl_pkg::lookup;
                                        stall <= 1'b1;
                                        write_q <= write_cpu && !read_cpu;  // read wins
                                end
                        cache_ctrl_pkg::lookup:
                                if (lk.hit)
                                begin
                                        state <= cache_ctrl_pkg::idle;
                                        stall <= 1'b0;
                                end
                                else
                                        state <= cache_ctrl_pkg::refill;
                        cache_ctrl_pkg::refill:
                                if (rf.done)
                                        state <= cache_ctrl_pkg::merge;
                        default:
                        begin
                                state <= cache_ctrl_pkg::idle;  // line installed this cycle
                                stall <= 1'b0;
                        end
                        endcase
                end
        end

        // request and read data latches
        always_ff @(posedge clk)
        begin
                if (accept)
                begin
                        addr_q <= addr_cpu;
                        wdata_q <= data_cpu_write;
                        byte_q <= byte_sel;
                end
                if (!write_q && (hit_now || state == cache_ctrl_pkg::merge))
                        data_cpu_read <= lk.rdata;
        end

        a_idle_no_stall: assert property (@(posedge clk) disable iff (reset)
                state == cache_ctrl_pkg::idle |-> !stall);

endmodule

// File: src/cache_top.sv
`timescale 1ns/100ps

module cache_top #(
        parameter int num_sets = cache_cfg_pkg::default_num_sets
) (
        input logic clk,
        input logic reset,
        input logic read_cpu,
        input logic write_cpu,
        input logic byte_sel,
        input cache_cfg_pkg::word_t data_cpu_write,
        input cache_cfg_pkg::addr_t addr_cpu,
        output cache_cfg_pkg::word_t data_cpu_read,
        output logic stall,
        input logic ready_mem,
        input logic mem_busy,
        input cache_cfg_pkg::line_t data_mem_read,
        output cache_cfg_pkg::line_t data_mem_write,
        output cache_cfg_pkg::addr_t addr_mem,
        output logic read_mem,
        output logic write_mem
);
        cache_cfg_pkg::line_t victim_line;

        lookup_if #(.num_sets(num_sets)) lk ();
        refill_if rf ();

        cache_control u_control (
                .clk, .reset,
                .read_cpu, .write_cpu, .byte_sel,
                .data_cpu_write, .addr_cpu,
                .data_cpu_read, .stall,
                .lk(lk.ctrl), .rf(rf.ctrl)
        );

        tag_store #(.num_sets(num_sets)) u_tags (
                .clk, .reset, .lk(lk.tags)
        );

        data_store #(.num_sets(num_sets)) u_data (
                .clk, .reset, .lk(lk.data), .rf(rf.ctrl), .victim_line
        );

        mem_port u_mem_port (
                .clk, .reset, .rf(rf.port), .victim_line,
                .ready_mem, .mem_busy, .data_mem_read,
                .data_mem_write, .addr_mem, .read_mem, .write_mem
        );

endmodule

// File: tests/mem_model.sv
`timescale 1ns/100ps

// line wide memory with random latency and idle back-pressure
module mem_model #(
        parameter int seed = 1,
        parameter cache_cfg_pkg::word_t pattern = '0
) (
        input logic clk,
        input logic reset,
        input logic read_mem,
        input logic write_mem,
        input cache_cfg_pkg::addr_t addr_mem,
        input cache_cfg_pkg::line_t data_mem_write,
        output logic ready_mem,
        output logic mem_busy,
        output cache_cfg_pkg::line_t data_mem_read
);
        cache_cfg_pkg::line_t lines [cache_cfg_pkg::addr_t];    // written lines only
        int seed_v = seed;
        int rnd;
        int wait_cnt;
        logic pending;

        // unwritten words read as their own address mixed with the pattern
        function automatic cache_cfg_pkg::line_t line_at(input cache_cfg_pkg::addr_t a);
                cache_cfg_pkg::line_t l;
                if (lines.exists(a))
                        return lines[a];
                for (int i = 0; i < cache_cfg_pkg::line_words; i++)
                        l[i*cache_cfg_pkg::word_bits +: cache_cfg_pkg::word_bits] =
                                (a + 4*i) ^ pattern;
                return l;
        endfunction

        always @(posedge clk or posedge reset)
        begin
                if (reset)
                begin
                        ready_mem <= 1'b0;
                        mem_busy <= 1'b0;
                        pending <= 1'b0;
                        wait_cnt <= 0;
                        data_mem_read <= '0;
                end
                else
                begin
                        ready_mem <= 1'b0;
                        if (read_mem || write_mem)
                        begin
                                pending <= 1'b1;
                                mem_busy <= 1'b1;       // busy until the answer
                                wait_cnt <= 2 + $unsigned($random(seed_v)) % 5;
                                if (write_mem)
                                        lines[addr_mem] = data_mem_write;
                                else
                                        data_mem_read <= line_at(addr_mem);
                        end
                        else if (pending)
                        begin
                                if (wait_cnt <= 1)
                                begin
                                        ready_mem <= 1'b1;
                                        pending <= 1'b0;
                                end
                                wait_cnt <= wait_cnt - 1;
                        end
                        else
                        begin
                                rnd = $random(seed_v);
                                mem_busy <= rnd[0];     // random back-pressure when idle
                        end
                end
        end

endmodule

// File: tests/tb_cache.sv
`timescale 1ns/100ps

module tb_cache;

        localparam int period = 40;
        localparam int reset_cycles = 16;
        localparam int seed = 5;
        localparam int num_sets = 2;
        localparam int num_rows = 16;
        localparam cache_cfg_pkg::word_t pattern = 32'h5a3c_0f96;
        localparam logic rd_op = 1'b0;
        localparam logic wr_op = 1'b1;

        typedef struct packed {
                logic is_write;
                cache_cfg_pkg::addr_t addr;
                cache_cfg_pkg::word_t wdata;
                logic byte_sel;
                cache_cfg_pkg::word_t exp_rdata;
                int exp_fills;                  // read_mem pulses expected
                int exp_wbs;                    // write_mem pulses expected
                cache_cfg_pkg::addr_t wb_addr;
                cache_cfg_pkg::line_t wb_line;
        } row_t;

        logic clk = 1'b0;
        logic reset;
        logic read_cpu;
        logic write_cpu;
        logic byte_sel;
        cache_cfg_pkg::word_t data_cpu_write;
        cache_cfg_pkg::addr_t addr_cpu;
        cache_cfg_pkg::word_t data_cpu_read;
        logic stall;
        logic ready_mem;
        logic mem_busy;
        cache_cfg_pkg::line_t data_mem_read;
        cache_cfg_pkg::line_t data_mem_write;
        cache_cfg_pkg::addr_t addr_mem;
        logic read_mem;
        logic write_mem;

        row_t rows [num_rows];
        cache_cfg_pkg::word_t ref_mem [cache_cfg_pkg::addr_t];  // reference image by word
        cache_cfg_pkg::addr_t model_line [num_sets][2];
        logic [num_sets-1:0][1:0] model_valid = '0;
        logic [num_sets-1:0][1:0] model_dirty = '0;
        logic [num_sets-1:0] model_lru = '0;    // way to evict next

        // bus monitor results
        int rd_count = 0;
        int wr_count = 0;
        int rd_at_wr = 0;
        cache_cfg_pkg::addr_t rd_addr;
        cache_cfg_pkg::addr_t wr_addr;
        cache_cfg_pkg::line_t wr_line;

        always #(period/2) clk = ~clk;

        cache_top #(.num_sets(num_sets)) dut (
                .clk, .reset, .read_cpu, .write_cpu, .byte_sel,
                .data_cpu_write, .addr_cpu, .data_cpu_read, .stall,
                .ready_mem, .mem_busy, .data_mem_read,
                .data_mem_write, .addr_mem, .read_mem, .write_mem
        );

        mem_model #(.seed(seed), .pattern(pattern)) u_mem (
                .clk, .reset, .read_mem, .write_mem, .addr_mem, .data_mem_write,
                .ready_mem, .mem_busy, .data_mem_read
        );

        always @(posedge clk)
        begin
                if (read_mem)
                begin
                        rd_count <= rd_count + 1;
                        rd_addr <= addr_mem;
                end
                if (write_mem)
                begin
                        wr_count <= wr_count + 1;
                        wr_addr <= addr_mem;
                        wr_line <= data_mem_write;
                        rd_at_wr <= rd_count;   // fills seen before this writeback
                end
        end

        ////////////////////////////////////////
        // reference model
        ////////////////////////////////////////

        function automatic cache_cfg_pkg::word_t ref_word(input cache_cfg_pkg::addr_t a);
                return ref_mem.exists(a) ? ref_mem[a] : a ^ pattern;
        endfunction

        function automatic cache_cfg_pkg::line_t ref_line(input cache_cfg_pkg::addr_t a);
                cache_cfg_pkg::line_t l;
                for (int i = 0; i < cache_cfg_pkg::line_words; i++)
                        l[i*cache_cfg_pkg::word_bits +: cache_cfg_pkg::word_bits] =
                                ref_word(a + 4*i);
                return l;
        endfunction

        function automatic row_t predict(input row_t r);
                cache_cfg_pkg::addr_t line;
                cache_cfg_pkg::word_t w;
                int set;
                int way;
                line = {r.addr[31:4], 4'h0};
                set = int'(line[31:4]) % num_sets;
                way = -1;
                r.exp_fills = 0;
                r.exp_wbs = 0;
                for (int i = 0; i < 2; i++)
                        if (model_valid[set][i] && model_line[set][i] == line)
                                way = i;
                if (way < 0)
                begin
                        // an empty way goes first and then the lru way
                        way = !model_valid[set][0] ? 0 :
                              !model_valid[set][1] ? 1 : int'(model_lru[set]);
                        r.exp_fills = 1;
                        if (model_dirty[set][way])
                        begin
                                r.exp_wbs = 1;
                                r.wb_addr = model_line[set][way];
                                r.wb_line = ref_line(model_line[set][way]);
                        end
                        model_valid[set][way] = 1'b1;
                        model_dirty[set][way] = 1'b0;
                        model_line[set][way] = line;
                end
                model_lru[set] = (way == 0);
                w = ref_word({r.addr[31:2], 2'b00});
                if (r.is_write)
                begin
                        ref_mem[{r.addr[31:2], 2'b00}] = r.wdata;
                        model_dirty[set][way] = 1'b1;
                end
                else
                        r.exp_rdata = r.byte_sel ? cache_cfg_pkg::word_t'(w[r.addr[1:0]*8 +: 8]) :
                                                   w;
                return r;
        endfunction

        task automatic set_row(input int i, input logic is_write, input cache_cfg_pkg::addr_t addr,
                               input cache_cfg_pkg::word_t wdata, input logic bsel);
                rows[i] = '0;
                rows[i].is_write = is_write;
                rows[i].addr = addr;
                rows[i].wdata = wdata;
                rows[i].byte_sel = bsel;
        endtask

        ////////////////////////////////////////
        // checks
        ////////////////////////////////////////

        task automatic stop_with_failure();
                $display("STATUS: FAIL");
                $fatal(1, "stopped at the first error");
        endtask

        task automatic report_mismatch(input string name, input string got, input string exp);
                $display("FAILED at %0t ns: %s is %s, expected %s", $time, name, got, exp);
                stop_with_failure();
        endtask

        task automatic check_flag(input string name, input logic got, input logic exp);
                if (got !== exp)
                        report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
        endtask

        task automatic check_word(input string name, input cache_cfg_pkg::word_t got,
                                  input cache_cfg_pkg::word_t exp);
                if (got !== exp)
                        report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
        endtask

        task automatic check_addr(input string name, input cache_cfg_pkg::addr_t got,
                                  input cache_cfg_pkg::addr_t exp);
                if (got !== exp)
                        report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
        endtask

        task automatic check_line(input string name, input cache_cfg_pkg::line_t got,
                                  input cache_cfg_pkg::line_t exp);
                if (got !== exp)
                        report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
        endtask

        task automatic check_count(input string name, input int got, input int exp);
                if (got != exp)
                        report_mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
        endtask

        // the whole run gets a fixed budget of cycles per row
        initial
        begin
                #(period * (reset_cycles + 40 * num_rows));
                $display("timeout: the cache did not finish %0d requests in time", num_rows);
                stop_with_failure();
        end

        initial
        begin
                int stall_cycles;
                int rd_base;
                int wr_base;
                reset <= 1'b1;
                read_cpu <= 1'b0;
                write_cpu <= 1'b0;
                byte_sel <= 1'b0;
                data_cpu_write <= '0;
                addr_cpu <= '0;

                set_row(0, rd_op, 32'h0000_0100, '0, 1'b0);             // cold miss in set 0
                set_row(1, rd_op, 32'h0000_0108, '0, 1'b0);
                set_row(2, rd_op, 32'h0000_010d, '0, 1'b1);
                set_row(3, wr_op, 32'h0000_0104, 32'hdead_beef, 1'b0);  // write hit
                set_row(4, rd_op, 32'h0000_0104, '0, 1'b0);
                set_row(5, wr_op, 32'h0000_0210, 32'h1234_5678, 1'b0);  // write miss in set 1
                set_row(6, rd_op, 32'h0000_0210, '0, 1'b0);
                set_row(7, rd_op, 32'h0000_0213, '0, 1'b1);
                set_row(8, rd_op, 32'h0000_0300, '0, 1'b0);
                set_row(9, rd_op, 32'h0000_0500, '0, 1'b0);             // third tag evicts 0x100
                set_row(10, rd_op, 32'h0000_0104, '0, 1'b0);
                set_row(11, wr_op, 32'h0000_0508, 32'hcafe_f00d, 1'b0);
                set_row(12, wr_op, 32'h0000_0700, 32'h0bad_cafe, 1'b0);
                set_row(13, rd_op, 32'h0000_0508, '0, 1'b0);
                set_row(14, rd_op, 32'h0000_0700, '0, 1'b0);
                set_row(15, rd_op, 32'h0000_031f, '0, 1'b1);
                for (int i = 0; i < num_rows; i++)
                        rows[i] = predict(rows[i]);

                repeat (reset_cycles) @(posedge clk);
                reset <= 1'b0;
                @(posedge clk);
                check_flag("stall", stall, 1'b0);
                check_flag("read_mem", read_mem, 1'b0);
                check_flag("write_mem", write_mem, 1'b0);

                for (int i = 0; i < num_rows; i++)
                begin
                        rd_base = rd_count;
                        wr_base = wr_count;
                        read_cpu <= !rows[i].is_write;
                        write_cpu <= rows[i].is_write;
                        addr_cpu <= rows[i].addr;
                        data_cpu_write <= rows[i].wdata;
                        byte_sel <= rows[i].byte_sel;
                        @(posedge clk);                 // request sampled here
                        read_cpu <= 1'b0;
                        write_cpu <= 1'b0;
                        stall_cycles = 0;
                        @(posedge clk);
                        while (stall)
                        begin
                                stall_cycles++;
                                @(posedge clk);
                        end

                        check_count("read_mem pulses", rd_count - rd_base, rows[i].exp_fills);
                        check_count("write_mem pulses", wr_count - wr_base, rows[i].exp_wbs);
                        if (rows[i].exp_fills == 0)
                                check_count("stall cycles on hit", stall_cycles, 1);
                        else
                                check_addr("addr_mem on fill", rd_addr, {rows[i].addr[31:4], 4'h0});
                        if (rows[i].exp_wbs != 0)
                        begin
                                check_addr("addr_mem on writeback", wr_addr, rows[i].wb_addr);
                                check_line("data_mem_write", wr_line, rows[i].wb_line);
                                check_count("read_mem before writeback", rd_at_wr - rd_base, 0);
                        end
                        if (!rows[i].is_write)
                                check_word("data_cpu_read", data_cpu_read, rows[i].exp_rdata);
                end

                $display("STATUS: PASS");
                $finish;
        end

endmodule

// File: sources.f
src/cache_cfg_pkg.sv
src/cache_ctrl_pkg.sv
src/cache_ifs.sv
src/tag_store.sv
src/data_store.sv
src/mem_port.sv
src/cache_control.sv
src/cache_top.sv
tests/mem_model.sv
tests/tb_cache.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_cache -Mdir obj_dir -f sources.f &&
./obj_dir/Vtb_cache | tee /dev/stderr | grep -q "STATUS: PASS" ||
{ echo "simulation did not pass"; exit 1; }
